// ==== files.f ====
hw/stream_pkg.sv
hw/fifo_pkg.sv
hw/dp_ram.sv
hw/sync_fifo.sv
hw/fifo_out_stage.sv
hw/stream_buffer.sv
tb/tb_stream_buffer.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build the stream buffer testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
    --top-module tb_stream_buffer \
    -f files.f \
    -o sim_stream_buffer

# The pipe keeps the log even when the simulation stops early
./obj_dir/sim_stream_buffer 2>&1 | tee sim.log

if grep -q "STATUS: PASS" sim.log; then
    echo "Simulation passed"
else
    echo "Simulation failed"
    exit 1
fi

// ==== tb/tb_stream_buffer.sv ====
// Testbench for the stream buffer
// Phase table with a reference queue, random back-pressure and a watchdog

module tb_stream_buffer;

    // How out_ready behaves during a phase
    typedef enum logic [1:0] {
        rdy_rand,
        rdy_high,
        rdy_low
    } ready_mode_e;

    // One row of the stimulus table
    typedef struct packed {
        logic [7:0]  beats;
        ready_mode_e mode;
        logic        flush_after;
    } phase_t;

    localparam int num_phases = 6;

    // FIFO entries plus the two output stage slots
    localparam int capacity = fifo_pkg::fifo_depth + 2;

    localparam logic [fifo_pkg::level_width-1:0] full_level =
        fifo_pkg::level_width'(fifo_pkg::fifo_depth);

    // Single beats, capacity, long random run, flush mid-stream, restart, single beats
    phase_t phases [num_phases] = '{
        '{beats: 8'd4,  mode: rdy_high, flush_after: 1'b0},
        '{beats: 8'd10, mode: rdy_low,  flush_after: 1'b0},
        '{beats: 8'd40, mode: rdy_rand, flush_after: 1'b0},
        '{beats: 8'd20, mode: rdy_rand, flush_after: 1'b1},
        '{beats: 8'd30, mode: rdy_rand, flush_after: 1'b0},
        '{beats: 8'd3,  mode: rdy_high, flush_after: 1'b0}
    };

    logic                             clk;
    logic                             n_rst;
    logic                             flush;
    logic                             in_valid;
    logic                             in_ready;
    stream_pkg::stream_beat_t         in_beat;
    logic                             out_valid;
    logic                             out_ready;
    stream_pkg::stream_beat_t         out_beat;
    logic [fifo_pkg::level_width-1:0] level;

    // Beats accepted and not yet seen at the egress
    stream_pkg::stream_beat_t ref_q [$];

    // Ingress transfer due at the next rising edge
    logic in_take = 1'b0;

    int errors    = 0;
    int beats_in  = 0;
    int beats_out = 0;

    logic [31:0] rng_state;
    int          beat_idx;
    ready_mode_e ready_mode;

    stream_buffer DUT (
        .clk       (clk),
        .n_rst     (n_rst),
        .flush     (flush),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .in_beat   (in_beat),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_beat  (out_beat),
        .level     (level)
    );

    always #4 clk = ~clk;

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // Random payload, every fourth beat closes a frame
    function automatic stream_pkg::stream_beat_t make_beat();
        stream_pkg::stream_beat_t b;
        rng_state = xorshift32(rng_state);
        b.data    = rng_state[stream_pkg::data_width-1:0];
        b.last    = (beat_idx % 4) == 3;
        beat_idx++;
        return b;
    endfunction

    task automatic report_error(input string msg);
        errors++;
        $display("CHECK FAILED at %0t: %s", $time, msg);
    endtask

    // Mid-cycle monitor, all handshakes are stable here
    always @(negedge clk) begin
        stream_pkg::stream_beat_t exp;
        if (n_rst) begin
            in_take = in_valid && in_ready;
            if (flush && in_ready) begin
                report_error("in_ready high during flush");
            end
            if (in_take) begin
                ref_q.push_back(in_beat);
                beats_in++;
            end
            if (out_valid && out_ready) begin
                beats_out++;
                if (ref_q.size() == 0) begin
                    report_error($sformatf("unexpected output beat %h", out_beat));
                end else begin
                    exp = ref_q.pop_front();
                    if (out_beat !== exp) begin
                        report_error($sformatf("out_beat %h, expected %h", out_beat, exp));
                    end
                end
            end
            if (level > full_level) begin
                report_error($sformatf("level %0d above FIFO depth", level));
            end
            // Egress at the flush edge still counts, everything after is gone
            if (flush) begin
                ref_q.delete();
            end
        end
    end

    // Advance to the next rising edge and update random back-pressure
    task automatic next_cycle();
        @(posedge clk);
        if (ready_mode == rdy_rand) begin
            rng_state = xorshift32(rng_state);
            out_ready <= rng_state[0];
        end
    endtask

    // Hold a beat on the ingress until it transfers
    task automatic offer_beat(input stream_pkg::stream_beat_t b);
        in_valid <= 1'b1;
        in_beat  <= b;
        do begin
            next_cycle();
        end while (!in_take);
    endtask

    // Two quiet cycles rule out a read still in flight
    task automatic wait_idle();
        int quiet;
        quiet = 0;
        while (quiet < 2) begin
            @(negedge clk);
            if (!out_valid && level == '0) begin
                quiet++;
            end else begin
                quiet = 0;
            end
        end
        next_cycle();
    endtask

    task automatic drain();
        ready_mode = rdy_high;
        out_ready <= 1'b1;
        wait_idle();
        if (ref_q.size() != 0) begin
            report_error($sformatf("%0d beats never left the buffer", ref_q.size()));
        end
    endtask

    // One beat at a time into an empty buffer with latency checks
    task automatic run_single(input int count);
        ready_mode = rdy_high;
        out_ready <= 1'b1;
        for (int n = 0; n < count; n++) begin
            offer_beat(make_beat());
            in_valid <= 1'b0;
            // Popped on the next edge, captured one edge later
            next_cycle();
            @(negedge clk);
            if (out_valid) begin
                report_error("out_valid high one cycle after accept");
            end
            next_cycle();
            @(negedge clk);
            if (!out_valid) begin
                report_error("out_valid low two cycles after accept");
            end
            wait_idle();
        end
    endtask

    // Fill with the egress stalled until the ingress stops accepting
    task automatic run_capacity();
        int accepted;
        int stall;
        accepted = 0;
        stall    = 0;
        ready_mode = rdy_low;
        out_ready <= 1'b0;
        in_valid  <= 1'b1;
        in_beat   <= make_beat();
        while (stall < 4) begin
            next_cycle();
            if (in_take) begin
                accepted++;
                stall = 0;
                in_beat <= make_beat();
            end else begin
                stall++;
            end
        end
        in_valid <= 1'b0;
        if (accepted != capacity) begin
            report_error($sformatf("accepted %0d beats, expected %0d", accepted, capacity));
        end
        @(negedge clk);
        if (level != full_level) begin
            report_error($sformatf("level %0d with a full buffer", level));
        end
        if (in_ready) begin
            report_error("in_ready high with a full buffer");
        end
        next_cycle();
    endtask

    // Back-to-back input against random out_ready
    task automatic run_stream(input int count);
        ready_mode = rdy_rand;
        for (int n = 0; n < count; n++) begin
            offer_beat(make_beat());
        end
        in_valid <= 1'b0;
    endtask

    // Beat offered in the flush cycle must be refused
    task automatic apply_flush();
        flush    <= 1'b1;
        in_valid <= 1'b1;
        in_beat  <= make_beat();
        next_cycle();
        flush    <= 1'b0;
        in_valid <= 1'b0;
        @(negedge clk);
        if (out_valid) begin
            report_error("out_valid high after flush");
        end
        if (level != '0) begin
            report_error($sformatf("level %0d after flush", level));
        end
        next_cycle();
    endtask

    initial begin
        clk        = 1'b0;
        n_rst     <= 1'b0;
        flush     <= 1'b0;
        in_valid  <= 1'b0;
        in_beat   <= '0;
        out_ready <= 1'b0;
        rng_state  = 32'h8b43_47e2;
        beat_idx   = 0;
        ready_mode = rdy_low;

        repeat (8) @(posedge clk);
        n_rst <= 1'b1;
        @(negedge clk);
        if (out_valid) begin
            report_error("out_valid high after reset");
        end
        if (level != '0) begin
            report_error($sformatf("level %0d after reset", level));
        end
        if (!in_ready) begin
            report_error("in_ready low after reset");
        end
        next_cycle();

        foreach (phases[i]) begin
            case (phases[i].mode)
                rdy_high: run_single(int'(phases[i].beats));
                rdy_low:  run_capacity();
                default:  run_stream(int'(phases[i].beats));
            endcase
            if (phases[i].flush_after) begin
                apply_flush();
            end else begin
                drain();
            end
        end

        $display("Run done: %0d errors, %0d beats in, %0d beats out",
                 errors, beats_in, beats_out);
        if (errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

    // Budget of 20 cycles per table beat plus margin
    initial begin
        int total;
        total = 0;
        foreach (phases[i]) begin
            total += int'(phases[i].beats);
        end
        repeat (total * 20 + 200) @(posedge clk);
        $display("Watchdog expired after %0d cycles, the run did not finish",
                 total * 20 + 200);
        $display("STATUS: FAIL");
        $finish;
    end

endmodule

// ==== hw/stream_buffer.sv ====
// Stream buffer top level
// Valid/ready ingress into a FIFO, drained through the output stage

module stream_buffer (
    input  logic                                clk,
    input  logic                                n_rst,
    input  logic                                flush,
    input  logic                                in_valid,
    output logic                                in_ready,
    input  stream_pkg::stream_beat_t            in_beat,
    output logic                                out_valid,
    input  logic                                out_ready,
    output stream_pkg::stream_beat_t            out_beat,
    output logic [fifo_pkg::level_width-1:0]    level
);

    // FIFO status and handshake
    logic full;
    logic empty;
    logic push;
    logic pop;

    // FIFO read data into the output stage
    stream_pkg::stream_beat_t fifo_rd_data;

    // Nothing is accepted during a flush
    assign in_ready = ~full & ~flush;
    assign push     = in_valid & in_ready;

    // Storage
    sync_fifo u_fifo (
        .clk       (clk),
        .n_rst     (n_rst),
        .flush     (flush),
        .push      (push),
        .push_beat (in_beat),
        .full      (full),
        .pop       (pop),
        .empty     (empty),
        .rd_data   (fifo_rd_data),
        .level     (level)
    );

    // Egress
    fifo_out_stage u_out_stage (
        .clk       (clk),
        .n_rst     (n_rst),
        .flush     (flush),
        .empty     (empty),
        .pop       (pop),
        .rd_data   (fifo_rd_data),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_beat  (out_beat)
    );

endmodule

// ==== hw/fifo_out_stage.sv ====
// FIFO output stage with two beats of buffering
// Hides the RAM read latency and drives a valid/ready egress port

module fifo_out_stage (
    input  logic                     clk,
    input  logic                     n_rst,
    input  logic                     flush,
    input  logic                     empty,
    output logic                     pop,
    input  stream_pkg::stream_beat_t rd_data,
    output logic                     out_valid,
    input  logic                     out_ready,
    output stream_pkg::stream_beat_t out_beat
);

    // Held beat count
    stream_pkg::out_state_e state;
    stream_pkg::out_state_e state_nxt;

    // Read issued last cycle, data on rd_data now
    logic in_flight;

    // Head is presented, second waits behind it
    stream_pkg::stream_beat_t head;
    stream_pkg::stream_beat_t second;

    // Egress transfer this cycle
    logic out_xfer;

    // Beats held after this edge counting the returning read
    logic [2:0] fill_after;

    assign out_valid = (state != stream_pkg::os_empty);
    assign out_beat  = head;
    assign out_xfer  = out_valid & out_ready;

    // No underflow since a transfer implies a held beat
    assign fill_after = {1'b0, state} + {2'b0, in_flight} - {2'b0, out_xfer};

    // Pop only if the beat it returns will find a free slot
    // Counting the departing beat keeps one beat per cycle flowing
    assign pop = ~empty & (fill_after < 3'd2);

    // Next count from arrival and departure
    always_comb begin
        state_nxt = state;
        case (state)
            stream_pkg::os_empty: begin
                if (in_flight) begin
                    state_nxt = stream_pkg::os_one;
                end
            end
            stream_pkg::os_one: begin
                if (out_xfer && !in_flight) begin
                    state_nxt = stream_pkg::os_empty;
                end else if (!out_xfer && in_flight) begin
                    state_nxt = stream_pkg::os_two;
                end
            end
            stream_pkg::os_two: begin
                // No read is in flight here
                if (out_xfer) begin
                    state_nxt = stream_pkg::os_one;
                end
            end
            default: begin
                state_nxt = stream_pkg::os_empty;
            end
        endcase
    end

    // Count and in-flight flag, flush drops any pending read
    always_ff @(posedge clk, negedge n_rst) begin
        if (!n_rst) begin
            state     <= stream_pkg::os_empty;
            in_flight <= 1'b0;
        end else if (flush) begin
            state     <= stream_pkg::os_empty;
            in_flight <= 1'b0;
        end else begin
            state     <= state_nxt;
            in_flight <= pop;
        end
    end

    // Beat slots
    always_ff @(posedge clk) begin
        case (state)
            stream_pkg::os_empty: begin
                if (in_flight) begin
                    head <= rd_data;
                end
            end
            stream_pkg::os_one: begin
                // Arriving beat replaces a leaving head, else queues behind it
                if (in_flight && out_xfer) begin
                    head <= rd_data;
                end else if (in_flight) begin
                    second <= rd_data;
                end
            end
            stream_pkg::os_two: begin
                if (out_xfer) begin
                    head <= second;
                end
            end
            default: begin
                head <= head;
            end
        endcase
    end

    // Egress beat holds while stalled
    out_beat_stable: assert property (
        @(posedge clk) disable iff (!n_rst)
        (out_valid && !out_ready && !flush) |=> $stable(out_beat)
    ) else $error("out_beat changed under back-pressure");

    // Pop gating keeps a full stage from having a read outstanding
    no_overrun: assert property (
        @(posedge clk) disable iff (!n_rst)
        !(state == stream_pkg::os_two && in_flight)
    ) else $error("read in flight with both slots held");

endmodule

// ==== hw/sync_fifo.sv ====
// Synchronous FIFO on a dual-port RAM
// Wrap-bit pointers give full, empty and the fill level; flush empties it

module sync_fifo (
    input  logic                                clk,
    input  logic                                n_rst,
    input  logic                                flush,
    input  logic                                push,
    input  stream_pkg::stream_beat_t            push_beat,
    output logic                                full,
    input  logic                                pop,
    output logic                                empty,
    output stream_pkg::stream_beat_t            rd_data,
    output logic [fifo_pkg::level_width-1:0]    level
);

    // Index of the wrap bit
    localparam int wrap_bit = fifo_pkg::ptr_width - 1;

    // Pointers with wrap bit on top
    logic [fifo_pkg::ptr_width-1:0] wr_ptr;
    logic [fifo_pkg::ptr_width-1:0] rd_ptr;

    // Pointer enables
    logic wr_ptr_en;
    logic rd_ptr_en;

    // RAM port bundles
    fifo_pkg::ram_wr_t ram_wr;
    fifo_pkg::ram_rd_t ram_rd;

    // Writes are dropped when full
    assign wr_ptr_en = push & ~full;

    // Output stage only pops a non-empty FIFO
    assign rd_ptr_en = pop;

    // Full when addresses match and wrap bits differ
    assign full  = ({~wr_ptr[wrap_bit], wr_ptr[wrap_bit-1:0]} == rd_ptr);
    assign empty = (wr_ptr == rd_ptr);

    // Modulo difference stays correct across the wrap
    assign level = wr_ptr - rd_ptr;

    // RAM is addressed without the wrap bit
    assign ram_wr.wr_en   = wr_ptr_en;
    assign ram_wr.wr_addr = wr_ptr[wrap_bit-1:0];
    assign ram_wr.wr_data = push_beat;

    assign ram_rd.rd_en   = rd_ptr_en;
    assign ram_rd.rd_addr = rd_ptr[wrap_bit-1:0];

    // Write pointer
    always_ff @(posedge clk, negedge n_rst) begin
        if (!n_rst) begin
            wr_ptr <= '0;
        end else if (flush) begin
            wr_ptr <= '0;
        end else if (wr_ptr_en) begin
            wr_ptr <= wr_ptr + 1'b1;
        end
    end

    // Read pointer
    always_ff @(posedge clk, negedge n_rst) begin
        if (!n_rst) begin
            rd_ptr <= '0;
        end else if (flush) begin
            rd_ptr <= '0;
        end else if (rd_ptr_en) begin
            rd_ptr <= rd_ptr + 1'b1;
        end
    end

    // Storage
    dp_ram fifo_mem (
        .clk     (clk),
        .n_rst   (n_rst),
        .wr      (ram_wr),
        .rd      (ram_rd),
        .rd_data (rd_data)
    );

    // Pointers never drift further apart than the RAM depth
    level_in_range: assert property (
        @(posedge clk) disable iff (!n_rst)
        int'(level) <= fifo_pkg::fifo_depth
    ) else $error("sync_fifo level beyond depth");

    // Output stage must check empty before popping
    no_pop_empty: assert property (
        @(posedge clk) disable iff (!n_rst)
        empty |-> !pop
    ) else $error("sync_fifo popped while empty");

endmodule

// ==== hw/dp_ram.sv ====
// Dual-port RAM for the FIFO storage
// One write port and one read port with a registered output

module dp_ram (
    input  logic                     clk,
    input  logic                     n_rst,
    input  fifo_pkg::ram_wr_t        wr,
    input  fifo_pkg::ram_rd_t        rd,
    output stream_pkg::stream_beat_t rd_data
);

    // Storage array
    stream_pkg::stream_beat_t mem [fifo_pkg::fifo_depth];

    // Write port
    always_ff @(posedge clk) begin
        if (wr.wr_en) begin
            mem[wr.wr_addr] <= wr.wr_data;
        end
    end

    // Read port, output held between reads
    always_ff @(posedge clk, negedge n_rst) begin
        if (!n_rst) begin
            rd_data <= '0;
        end else if (rd.rd_en) begin
            rd_data <= mem[rd.rd_addr];
        end
    end

    // An enabled port must see a known address
    wr_addr_known: assert property (
        @(posedge clk) disable iff (!n_rst)
        wr.wr_en |-> !$isunknown(wr.wr_addr)
    ) else $error("dp_ram write with unknown address");

    rd_addr_known: assert property (
        @(posedge clk) disable iff (!n_rst)
        rd.rd_en |-> !$isunknown(rd.rd_addr)
    ) else $error("dp_ram read with unknown address");

endmodule

// ==== hw/fifo_pkg.sv ====
// Storage definitions for the stream FIFO
// Depth, pointer widths and the RAM port bundles

package fifo_pkg;

    // Number of RAM entries
    localparam int fifo_depth = 8;

    // RAM address bits
    localparam int addr_width = $clog2(fifo_depth);

    // Pointers carry one extra wrap bit to tell full from empty
    localparam int ptr_width = addr_width + 1;

    // Fill level spans 0 to fifo_depth inclusive
    localparam int level_width = ptr_width;

    // RAM write port
    typedef struct packed {
        logic                       wr_en;
        logic [addr_width-1:0]      wr_addr;
        stream_pkg::stream_beat_t   wr_data;
    } ram_wr_t;

    // RAM read port, data returns one cycle later
    typedef struct packed {
        logic                  rd_en;
        logic [addr_width-1:0] rd_addr;
    } ram_rd_t;

endpackage

// ==== hw/stream_pkg.sv ====
// Stream definitions shared by the buffer blocks
// Beat layout and the output stage state type

package stream_pkg;

    // Payload bits carried by one beat
    localparam int data_width = 8;

    // One beat on the stream
    // last flags the final beat of a frame
    typedef struct packed {
        logic [data_width-1:0] data;
        logic                  last;
    } stream_beat_t;

    // Number of beats held in the output stage
    // Value matches the count so it can be used in arithmetic
    typedef enum logic [1:0] {
        os_empty = 2'd0,
        os_one   = 2'd1,
        os_two   = 2'd2
    } out_state_e;

endpackage
